// ==== tb.f ====
+incdir+common
common/fp_format_pkg.sv
common/cast_op_pkg.sv
src/cast_decode.sv
src/cast_execute.sv
src/cast_result.sv
src/fp_int_cast.sv
verif/fp_int_cast_asserts.sv
verif/tb_fp_int_cast.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cast unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/100ps \
  --top-module tb_fp_int_cast -f tb.f -o tb_fp_int_cast

# Nonzero exit on any $fatal or failed assertion
./obj_dir/tb_fp_int_cast

// ==== verif/tb_fp_int_cast.sv ====
// -----------------------------------------------
// Float/integer cast testbench
// Directed and random F2I/I2F stimulus, with a
// queue of expected values built from the IEEE
// rounding and saturation rules
// -----------------------------------------------
`timescale 1ns/100ps
`include "cast_settings.svh"

module tb_fp_int_cast import fp_format_pkg::*, cast_op_pkg::*; ();

  typedef struct packed {
    logic [`CAST_INT_WIDTH-1:0] result;
    cast_status_t               status;
  } expect_t;

  logic                       clk_i;
  logic                       reset_i;
  logic                       in_valid_i;
  operand_u                   operand_i;
  cast_op_e                   op_i;
  round_mode_e                rnd_mode_i;
  logic                       op_mod_i;
  logic [`CAST_INT_WIDTH-1:0] result_o;
  cast_status_t               status_o;
  logic                       out_valid_o;
  expect_t                    exp_q[$];  // Oldest input first

  fp_int_cast i_fp_int_cast (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_valid_i  ( in_valid_i  ),
    .operand_i   ( operand_i   ),
    .op_i        ( op_i        ),
    .rnd_mode_i  ( rnd_mode_i  ),
    .op_mod_i    ( op_mod_i    ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .out_valid_o ( out_valid_o )
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic logic increment_needed(input round_mode_e rm, input logic sign,
      input logic lsb, input logic inexact, input logic eq_half, input logic gt_half);
    case (rm)
      RNE:     return gt_half || (eq_half && lsb);  // Ties to even
      RDN:     return inexact && sign;
      RUP:     return inexact && !sign;
      RMM:     return gt_half || eq_half;           // Ties away
      default: return 1'b0;                         // RTZ
    endcase
  endfunction

  function automatic expect_t f2i_model(input logic [31:0] w, input round_mode_e rm,
                                        input logic uns);
    expect_t     e;
    int          unb;
    int          s;
    logic        is_nan;
    logic [63:0] mant;
    logic [63:0] mag;
    logic [63:0] frac;
    logic        inexact;
    logic        eq_half;
    logic        gt_half;
    e       = '0;
    unb     = int'(w[30:23]) - 127;
    is_nan  = (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
    mant    = {40'd0, w[30:23] != 8'd0, w[22:0]};  // Implicit bit unless subnormal
    mag     = '0;
    inexact = 1'b0;
    eq_half = 1'b0;
    gt_half = 1'b0;
    if (w[30:23] == 8'hff || unb >= (uns ? 32 : 31)) begin
      e.status.nv = 1'b1;
      if (w[31] && !is_nan) e.result = uns ? 32'h0 : 32'h8000_0000;
      else e.result = uns ? 32'hffff_ffff : 32'h7fff_ffff;
    end else begin
      if (unb >= 23) begin
        mag = mant << (unb - 23);  // Exact
      end else if (unb >= -1) begin
        s       = 23 - unb;
        mag     = mant >> s;
        frac    = mant & ((64'd1 << s) - 64'd1);
        inexact = (frac != '0);
        eq_half = (frac == (64'd1 << (s - 1)));
        gt_half = (frac > (64'd1 << (s - 1)));
      end else begin
        inexact = (mant != '0);  // Below one half
      end
      mag = mag + 64'(increment_needed(rm, w[31], mag[0], inexact, eq_half, gt_half));
      if (w[31] && uns && mag != '0) begin
        e.status.nv = 1'b1;  // Negative to unsigned
      end else begin
        e.result    = w[31] ? ~mag[31:0] + 32'd1 : mag[31:0];
        e.status.nx = inexact;
      end
    end
    return e;
  endfunction

  function automatic expect_t i2f_model(input logic [31:0] w, input round_mode_e rm,
                                        input logic uns);
    expect_t     e;
    logic        sign;
    logic [31:0] m;
    logic [31:0] kept;
    logic [31:0] frac;
    logic [24:0] mant;
    logic [7:0]  expo;
    int          p;
    int          d;
    e    = '0;
    p    = 0;
    sign = w[31] && !uns;
    m    = sign ? ~w + 32'd1 : w;
    for (int i = 0; i < 32; i++) begin
      if (m[i]) p = i;  // Leading one
    end
    expo = 8'(127 + p);
    if (p <= 23) begin
      kept = m << (23 - p);
      mant = kept[24:0];
    end else begin
      d           = p - 23;
      kept        = m >> d;
      frac        = m & ((32'd1 << d) - 32'd1);
      e.status.nx = (frac != '0);
      mant = kept[24:0] + 25'(increment_needed(rm, sign, kept[0], e.status.nx,
                                               frac == (32'd1 << (d - 1)),
                                               frac > (32'd1 << (d - 1))));
      if (mant[24]) begin
        expo = expo + 8'd1;  // Carry into the exponent
        mant = mant >> 1;
      end
    end
    if (m != '0) e.result = {sign, expo, mant[22:0]};
    return e;
  endfunction

  // ------------------------------------------------
  // Stimulus and failure helpers
  // ------------------------------------------------
  task automatic stop_run(input string why);
    $display("Test FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Fail at %0t ns: %s got %h, expected %h", $time, name, got, want);
    stop_run("output value mismatch");
  endtask

  task automatic send(input cast_op_e op, input logic [31:0] word, input round_mode_e rm,
                      input logic uns);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    operand_i  <= word;
    op_i       <= op;
    rnd_mode_i <= rm;
    op_mod_i   <= uns;
    if (op == F2I) exp_q.push_back(f2i_model(word, rm, uns));
    else exp_q.push_back(i2f_model(word, rm, uns));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      in_valid_i <= 1'b0;
    end
  endtask

  // ------------------------------------------------
  // Output checking
  // ------------------------------------------------
  initial begin : check_loop
    int      waited;
    expect_t exp_v;
    forever begin
      @(negedge clk_i);  // Outputs settled here
      if (!reset_i && exp_q.size() != 0) begin
        waited = 0;
        while (!out_valid_o && waited < 4) begin
          @(negedge clk_i);
          waited++;
        end
        if (!out_valid_o) begin
          stop_run("no out_valid_o within 4 cycles of an input");
        end else begin
          exp_v = exp_q.pop_front();
          assert (result_o === exp_v.result && status_o === exp_v.status) else begin
            if (result_o !== exp_v.result) report_mismatch("result_o", result_o, exp_v.result);
            else report_mismatch("status_o", {30'd0, status_o}, {30'd0, exp_v.status});
          end
        end
      end else if (!reset_i && out_valid_o) begin
        stop_run("out_valid_o high with no input pending");
      end
    end
  end

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin : main_seq
    cast_op_e    op;
    logic [31:0] word;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    in_valid_i = 1'b1;  // Strobe during reset must not reach out_valid_o
    operand_i  = '0;
    op_i       = F2I;
    rnd_mode_i = RNE;
    op_mod_i   = 1'b0;
    void'($urandom(32'h7e08));
    repeat (6) @(posedge clk_i);
    in_valid_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    idle(2);

    // Ties and fractions in every mode on consecutive cycles
    for (int m = 0; m < 5; m++) begin
      send(F2I, 32'h4020_0000, round_mode_e'(3'(m)), 1'b0);  // 2.5
      send(F2I, 32'hc020_0000, round_mode_e'(3'(m)), 1'b0);  // -2.5
      send(F2I, 32'h3fc0_0000, round_mode_e'(3'(m)), 1'b0);  // 1.5
      send(F2I, 32'h3f00_0000, round_mode_e'(3'(m)), 1'b1);  // 0.5
      send(F2I, 32'hbe99_999a, round_mode_e'(3'(m)), 1'b1);  // -0.3 to unsigned
      send(I2F, 32'h7fff_ffff, round_mode_e'(3'(m)), 1'b0);
      send(I2F, 32'h0100_0003, round_mode_e'(3'(m)), 1'b0);  // Tie above 2^24
      send(I2F, 32'h8000_0001, round_mode_e'(3'(m)), 1'b0);
    end
    // Specials for signed then unsigned
    for (int u = 0; u < 2; u++) begin
      send(F2I, 32'h7fc0_0000, RNE, 1'(u));  // qNaN
      send(F2I, 32'hff80_0001, RNE, 1'(u));  // Negative sNaN
      send(F2I, 32'h7f80_0000, RNE, 1'(u));
      send(F2I, 32'hff80_0000, RNE, 1'(u));
      send(F2I, 32'h4f00_0000, RTZ, 1'(u));  // 2^31
      send(F2I, 32'hcf00_0000, RTZ, 1'(u));
      send(F2I, 32'h4f80_0000, RTZ, 1'(u));  // 2^32
      send(F2I, 32'hc0a0_0000, RNE, 1'(u));  // -5.0
      send(F2I, 32'h8000_0000, RNE, 1'(u));  // -0
      send(F2I, 32'h0000_0001, RUP, 1'(u));  // Smallest subnormal
      send(I2F, 32'h0000_0000, RNE, 1'(u));
      send(I2F, 32'hffff_ffff, RNE, 1'(u));
      send(I2F, 32'h8000_0000, RDN, 1'(u));
    end
    idle(2);

    // Random vectors with F2I exponents mostly near the integer range
    for (int n = 0; n < 400; n++) begin
      op   = cast_op_e'(1'($urandom_range(0, 1)));
      word = $urandom;
      if (op == F2I && $urandom_range(0, 3) != 0) begin
        word[30:23] = 8'($urandom_range(110, 162));
      end
      send(op, word, round_mode_e'(3'($urandom_range(0, 4))), 1'($urandom_range(0, 1)));
      if ($urandom_range(0, 2) == 0) idle($urandom_range(1, 3));
    end
    idle(1);

    for (int i = 0; i < 16 && exp_q.size() != 0; i++) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      stop_run("results still pending at the end of the run");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== verif/fp_int_cast_asserts.sv ====
// -----------------------------------------------
// Cast unit assertions
// Output timing against the input strobe and the
// F2I saturation values, bound into the top level
// -----------------------------------------------
`timescale 1ns/100ps
`include "cast_settings.svh"

module fp_int_cast_asserts import fp_format_pkg::*, cast_op_pkg::*; (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       in_valid_i,
  input operand_u                   operand_i,
  input cast_op_e                   op_i,
  input logic                       op_mod_i,
  input logic [`CAST_INT_WIDTH-1:0] result_o,
  input cast_status_t               status_o,
  input logic                       out_valid_o
);

  logic                       in_nan;
  logic                       sat_in;
  logic [`CAST_INT_WIDTH-1:0] sat_val;

  assign in_nan = (operand_i.fp.exponent == '1) && (operand_i.fp.mantissa != '0);

  // NaN, infinity or exponent at 2^31, one higher for unsigned
  assign sat_in = in_valid_i && (op_i == F2I) &&
                  (operand_i.fp.exponent >=
                   8'(`CAST_BIAS + `CAST_INT_WIDTH - 1) + 8'(op_mod_i));

  assign sat_val = (operand_i.fp.sign && !in_nan) ?
                   (op_mod_i ? 32'h0000_0000 : 32'h8000_0000) :
                   (op_mod_i ? 32'hffff_ffff : 32'h7fff_ffff);

  reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset cycle");

  valid_follows_input: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i |=> out_valid_o)
    else $error("in_valid_i not followed by out_valid_o");

  valid_needs_input: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o |-> $past(in_valid_i))
    else $error("out_valid_o without in_valid_i one cycle before");

  saturates: assert property (@(posedge clk_i) disable iff (reset_i)
    sat_in |=> (result_o == $past(sat_val)) && status_o.nv && !status_o.nx)
    else $error("F2I special input not saturated with invalid flag");

endmodule

bind fp_int_cast fp_int_cast_asserts i_fp_int_cast_asserts (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .in_valid_i  ( in_valid_i  ),
  .operand_i   ( operand_i   ),
  .op_i        ( op_i        ),
  .op_mod_i    ( op_mod_i    ),
  .result_o    ( result_o    ),
  .status_o    ( status_o    ),
  .out_valid_o ( out_valid_o )
);

// ==== src/fp_int_cast.sv ====
// -----------------------------------------------
// Float/integer cast unit
// Binary32 to int32 and back, signed or unsigned,
// all IEEE rounding modes, one output register
// -----------------------------------------------
`timescale 1ns/100ps
`include "cast_settings.svh"

module fp_int_cast import fp_format_pkg::*, cast_op_pkg::*; (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       in_valid_i,   // One-cycle strobe
  input  operand_u                   operand_i,
  input  cast_op_e                   op_i,
  input  round_mode_e                rnd_mode_i,
  input  logic                       op_mod_i,     // Unsigned integer
  output logic [`CAST_INT_WIDTH-1:0] result_o,
  output cast_status_t               status_o,
  output logic                       out_valid_o
);

  decoded_t                   decoded;
  aligned_t                   aligned;
  logic [`CAST_INT_WIDTH-1:0] result_d;
  cast_status_t               status_d;

  cast_decode i_cast_decode (
    .operand_i ( operand_i ),
    .op_i      ( op_i      ),
    .op_mod_i  ( op_mod_i  ),
    .decoded_o ( decoded   )
  );

  cast_execute i_cast_execute (
    .decoded_i ( decoded  ),
    .op_i      ( op_i     ),
    .op_mod_i  ( op_mod_i ),
    .aligned_o ( aligned  )
  );

  cast_result i_cast_result (
    .aligned_i  ( aligned    ),
    .op_i       ( op_i       ),
    .op_mod_i   ( op_mod_i   ),
    .rnd_mode_i ( rnd_mode_i ),
    .result_o   ( result_d   ),
    .status_o   ( status_d   )
  );

  // ------------------------------------------------
  // Output register
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
      result_o    <= '0;
      status_o    <= '0;
    end else begin
      out_valid_o <= in_valid_i;
      if (in_valid_i) begin
        result_o <= result_d;  // Held while idle
        status_o <= status_d;
      end
    end
  end

endmodule

// ==== src/cast_result.sv ====
// -----------------------------------------------
// Cast result
// Rounds the aligned value, forms the two's
// complement integer, applies the saturating
// special cases and builds the status flags
// -----------------------------------------------
`timescale 1ns/100ps
`include "cast_settings.svh"

module cast_result import cast_op_pkg::*; (
  input  aligned_t                   aligned_i,
  input  cast_op_e                   op_i,
  input  logic                       op_mod_i,    // Unsigned integer
  input  round_mode_e                rnd_mode_i,
  output logic [`CAST_INT_WIDTH-1:0] result_o,
  output cast_status_t               status_o
);

  logic                       inexact;
  logic                       round_up;
  logic [`CAST_INT_WIDTH-1:0] rounded_abs;
  logic [`CAST_INT_WIDTH-1:0] rounded_int;
  logic                       rounded_int_zero;
  logic                       is_special;
  logic [`CAST_INT_WIDTH-1:0] special_res;

  // ------------------------------------------------
  // Rounding
  // ------------------------------------------------
  assign inexact = aligned_i.round_bit | aligned_i.sticky_bit;

  always_comb begin : round_decision
    unique case (rnd_mode_i)
      RNE: round_up = aligned_i.round_bit & (aligned_i.sticky_bit | aligned_i.value[0]);
      RTZ: round_up = 1'b0;
      RDN: round_up = inexact & aligned_i.sign;   // Away from zero when negative
      RUP: round_up = inexact & ~aligned_i.sign;  // Away from zero when positive
      RMM: round_up = aligned_i.round_bit;        // Ties away
      default: round_up = 1'b0;
    endcase
  end

  // Carry out of the mantissa steps the float exponent
  assign rounded_abs = aligned_i.value + `CAST_INT_WIDTH'(round_up);

  // Two's complement for negative integers
  assign rounded_int      = aligned_i.sign ? -rounded_abs : rounded_abs;
  assign rounded_int_zero = (rounded_int == '0);

  // ------------------------------------------------
  // F2I special cases
  // ------------------------------------------------
  assign is_special = aligned_i.info.is_nan | aligned_i.info.is_inf |
                      aligned_i.of_before_round |
                      (aligned_i.sign & op_mod_i & ~rounded_int_zero);  // Negative to unsigned

  always_comb begin : special_value
    special_res = {op_mod_i, {(`CAST_INT_WIDTH-1){1'b1}}};  // Positive max
    if (aligned_i.sign && !aligned_i.info.is_nan) begin
      special_res = ~special_res;  // Min, or zero for unsigned
    end
  end

  // ------------------------------------------------
  // Result and status
  // ------------------------------------------------
  always_comb begin : select_result
    if (op_i == I2F) begin
      result_o = {aligned_i.sign, rounded_abs[`CAST_INT_WIDTH-2:0]};
      status_o = '{nv: 1'b0, nx: inexact};
    end else if (is_special) begin
      result_o = special_res;
      status_o = '{nv: 1'b1, nx: 1'b0};  // Invalid only
    end else begin
      result_o = rounded_int;
      status_o = '{nv: 1'b0, nx: inexact};
    end
  end

endmodule

// ==== src/cast_execute.sv ====
// -----------------------------------------------
// Cast execute
// Normalizes the magnitude with a leading-zero
// count, then aligns it to integer position or
// packs a float field, with round and sticky bits
// -----------------------------------------------
`timescale 1ns/100ps
`include "cast_settings.svh"

module cast_execute import cast_op_pkg::*; (
  input  decoded_t decoded_i,
  input  cast_op_e op_i,
  input  logic     op_mod_i,   // Unsigned integer
  output aligned_t aligned_o
);

  // Mantissa on the left, room for round and sticky on the right
  localparam int unsigned SHIFT_WIDTH = 2 * `CAST_MAN_WIDTH + 1;
  localparam int unsigned SHAMT_W     = $clog2(SHIFT_WIDTH);

  logic [`CAST_SHAMT_WIDTH-1:0]      lz_cnt;
  logic [`CAST_MAN_WIDTH-1:0]        norm_mant;
  logic signed [`CAST_EXP_WIDTH-1:0] norm_exp;
  logic signed [`CAST_EXP_WIDTH-1:0] of_limit;
  logic [SHAMT_W-1:0]                f2i_shamt;
  logic                              f2i_of;
  logic [SHIFT_WIDTH-1:0]            shifted;
  logic [`CAST_EXP_BITS-1:0]         i2f_exp;

  // ------------------------------------------------
  // Leading-zero count and normalization
  // ------------------------------------------------
  always_comb begin : lzc
    lz_cnt = '0;
    for (int i = 0; i < `CAST_MAN_WIDTH; i++) begin
      if (decoded_i.magnitude[i]) begin
        lz_cnt = `CAST_SHAMT_WIDTH'(`CAST_MAN_WIDTH - 1 - i);  // Highest one wins
      end
    end
  end

  assign norm_mant = decoded_i.magnitude << lz_cnt;
  assign norm_exp  = decoded_i.exponent
                   - $signed({{(`CAST_EXP_WIDTH-`CAST_SHAMT_WIDTH){1'b0}}, lz_cnt});

  // ------------------------------------------------
  // F2I alignment
  // ------------------------------------------------
  // Unsigned range reaches one bit higher
  assign of_limit = `CAST_EXP_WIDTH'(`CAST_INT_WIDTH - 1) + `CAST_EXP_WIDTH'(op_mod_i);

  always_comb begin : f2i_align
    f2i_shamt = SHAMT_W'(`CAST_INT_WIDTH - 1 - norm_exp);  // Down to integer position
    f2i_of    = 1'b0;
    if (norm_exp >= of_limit) begin
      f2i_shamt = '0;
      f2i_of    = 1'b1;
    end else if (norm_exp < -1) begin
      f2i_shamt = SHAMT_W'(`CAST_INT_WIDTH + 1);  // Everything into sticky
    end
  end

  assign shifted = {norm_mant, {(SHIFT_WIDTH-`CAST_MAN_WIDTH){1'b0}}} >> f2i_shamt;

  // I2F exponent, never out of range for 32-bit input
  assign i2f_exp = `CAST_EXP_BITS'(norm_exp + `CAST_BIAS);

  // ------------------------------------------------
  // Output selection
  // ------------------------------------------------
  always_comb begin : select_aligned
    aligned_o.sign = decoded_i.sign;
    aligned_o.info = decoded_i.info;
    if (op_i == F2I) begin
      aligned_o.value           = shifted[SHIFT_WIDTH-1 -: `CAST_INT_WIDTH];
      aligned_o.round_bit       = shifted[SHIFT_WIDTH-1-`CAST_INT_WIDTH];
      aligned_o.sticky_bit      = |shifted[SHIFT_WIDTH-2-`CAST_INT_WIDTH:0];
      aligned_o.of_before_round = f2i_of;
    end else begin
      // Drop implicit bit, keep 23 bits below it
      aligned_o.value = `CAST_INT_WIDTH'({1'b0, i2f_exp,
                                          norm_mant[`CAST_MAN_WIDTH-2 -: `CAST_MAN_BITS]});
      aligned_o.round_bit       = norm_mant[`CAST_MAN_WIDTH-2-`CAST_MAN_BITS];
      aligned_o.sticky_bit      = |norm_mant[`CAST_MAN_WIDTH-3-`CAST_MAN_BITS:0];
      aligned_o.of_before_round = 1'b0;
      if (decoded_i.mag_is_zero) begin
        aligned_o.value = '0;  // Integer zero maps to +0
      end
    end
  end

endmodule

// ==== src/cast_decode.sv ====
// -----------------------------------------------
// Cast decode
// Classifies the operand as a binary32 value and
// extracts sign, unbiased exponent and magnitude
// from the float or the integer view of the word
// -----------------------------------------------
`timescale 1ns/100ps
`include "cast_settings.svh"

module cast_decode import fp_format_pkg::*, cast_op_pkg::*; (
  input  operand_u operand_i,
  input  cast_op_e op_i,
  input  logic     op_mod_i,   // Unsigned integer
  output decoded_t decoded_o
);

  fp32_t                             fp_val;
  logic [`CAST_INT_WIDTH-1:0]        int_val;
  logic                              exp_zero;
  logic                              exp_ones;
  logic                              man_zero;
  fp_info_t                          info;
  logic                              int_sign;
  logic [`CAST_MAN_WIDTH-1:0]        int_mag;
  logic [`CAST_MAN_WIDTH-1:0]        fp_mag;
  logic signed [`CAST_EXP_WIDTH-1:0] fp_exp;
  logic [`CAST_MAN_WIDTH-1:0]        mag_sel;

  // Both views of the same word
  assign fp_val  = operand_i.fp;
  assign int_val = operand_i.word;

  // ------------------------------------------------
  // Float classification
  // ------------------------------------------------
  assign exp_zero = (fp_val.exponent == '0);
  assign exp_ones = (fp_val.exponent == '1);
  assign man_zero = (fp_val.mantissa == '0);

  assign info.is_zero       = exp_zero & man_zero;
  assign info.is_subnormal  = exp_zero & ~man_zero;
  assign info.is_inf        = exp_ones & man_zero;
  assign info.is_nan        = exp_ones & ~man_zero;
  assign info.is_signalling = info.is_nan & ~fp_val.mantissa[`CAST_MAN_BITS-1];

  // Mantissa left aligned, implicit bit on top
  assign fp_mag = {~exp_zero, fp_val.mantissa,
                   {(`CAST_MAN_WIDTH-`CAST_MAN_BITS-1){1'b0}}};
  // Subnormals use exponent 1 - bias
  assign fp_exp = $signed({{(`CAST_EXP_WIDTH-`CAST_EXP_BITS){1'b0}}, fp_val.exponent})
                + $signed({{(`CAST_EXP_WIDTH-1){1'b0}}, info.is_subnormal})
                - `CAST_EXP_WIDTH'(`CAST_BIAS);

  // ------------------------------------------------
  // Integer magnitude
  // ------------------------------------------------
  assign int_sign = int_val[`CAST_INT_WIDTH-1] & ~op_mod_i;  // Only signed can be negative
  assign int_mag  = int_sign ? `CAST_MAN_WIDTH'(-int_val) : `CAST_MAN_WIDTH'(int_val);

  assign mag_sel = (op_i == I2F) ? int_mag : fp_mag;

  always_comb begin : select_source
    decoded_o.magnitude   = mag_sel;
    decoded_o.mag_is_zero = (mag_sel == '0);  // Integer zero
    decoded_o.info        = info;
    if (op_i == I2F) begin
      decoded_o.sign     = int_sign;
      decoded_o.exponent = `CAST_EXP_WIDTH'(`CAST_MAN_WIDTH - 1);  // LSB at weight 0
    end else begin
      decoded_o.sign     = fp_val.sign;
      decoded_o.exponent = fp_exp;
    end
  end

endmodule

// ==== common/cast_op_pkg.sv ====
// -----------------------------------------------
// Cast operation types
// Operation and rounding encodings, status flags
// and the records passed between the stages
// -----------------------------------------------
`include "cast_settings.svh"

package cast_op_pkg;
  import fp_format_pkg::*;

  typedef enum logic {
    F2I = 1'b0,
    I2F = 1'b1
  } cast_op_e;

  // IEEE rounding modes
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  typedef struct packed {
    logic nv;  // Invalid
    logic nx;  // Inexact
  } cast_status_t;

  // Decode to execute
  typedef struct packed {
    logic                              sign;
    logic signed [`CAST_EXP_WIDTH-1:0] exponent;   // Weight of magnitude MSB
    logic        [`CAST_MAN_WIDTH-1:0] magnitude;
    logic                              mag_is_zero;
    fp_info_t                          info;
  } decoded_t;

  // Execute to result
  typedef struct packed {
    logic [`CAST_INT_WIDTH-1:0] value;  // Truncated int or {exp, man}
    logic                       round_bit;
    logic                       sticky_bit;
    logic                       sign;
    logic                       of_before_round;
    fp_info_t                   info;
  } aligned_t;

endpackage

// ==== common/fp_format_pkg.sv ====
// -----------------------------------------------
// Number format types
// Binary32 fields, the dual-view operand word and
// the classification flags of a float operand
// -----------------------------------------------
`include "cast_settings.svh"

package fp_format_pkg;

  // Binary32 split into fields
  typedef struct packed {
    logic                      sign;
    logic [`CAST_EXP_BITS-1:0] exponent;  // Biased
    logic [`CAST_MAN_BITS-1:0] mantissa;  // Without implicit bit
  } fp32_t;

  // Same word seen as float or as raw integer
  typedef union packed {
    fp32_t                      fp;
    logic [`CAST_INT_WIDTH-1:0] word;
  } operand_u;

  // Float operand classification
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;  // Quiet bit clear
  } fp_info_t;

endpackage

// ==== common/cast_settings.svh ====
// -----------------------------------------------
// Cast unit settings
// Binary32 field widths, exponent bias and the
// internal datapath widths of the float/int cast
// -----------------------------------------------
`ifndef CAST_SETTINGS_SVH
`define CAST_SETTINGS_SVH

// Binary32 fields
`define CAST_EXP_BITS 8
`define CAST_MAN_BITS 23
`define CAST_BIAS 127

// Integer word, also the operand width
`define CAST_INT_WIDTH 32

// Internal mantissa is max(MAN_BITS+1, INT_WIDTH)
`define CAST_MAN_WIDTH 32
// Signed unbiased exponent
`define CAST_EXP_WIDTH 10
// Leading-zero count of the internal mantissa
`define CAST_SHAMT_WIDTH 5

`endif
